//--- mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// ------------------------------
// Datapath widths
// ------------------------------
`define MIPS_NB_DATA            32
`define MIPS_NB_REG_ADDRESS     5
`define MIPS_NB_OP_FIELD        6

// ------------------------------
// Memory sizes
// ------------------------------
// Word addresses, data memory is indexed by byte address bits 8:2
`define MIPS_NB_MEM_ADDRESS     7
`define MIPS_NB_IMEM_ADDRESS    7
`define MIPS_DMEM_DEPTH         128
`define MIPS_IMEM_DEPTH         128

// Opcode that stops fetch and ends the program
`define MIPS_HALT_OPCODE        6'h3f

`endif

//--- mips_pkg.sv
`include "mips_params.svh"

package mips_pkg;

    typedef logic [`MIPS_NB_DATA         - 1 : 0] word_t;
    typedef logic [`MIPS_NB_REG_ADDRESS  - 1 : 0] reg_addr_t;
    typedef logic [`MIPS_NB_MEM_ADDRESS  - 1 : 0] mem_addr_t;
    typedef logic [`MIPS_NB_IMEM_ADDRESS - 1 : 0] imem_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // Four-phase receiver states
    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_WRITE,
        LOAD_WAIT_RELEASE
    } load_state_t;

    // ------------------------------
    // Stage registers
    // ------------------------------
    typedef struct packed {
        logic      valid;
        logic      halt;
        word_t     instruction;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        logic      halt;
        alu_op_t   alu_op;
        logic      alu_src_imm;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        word_t     data_a;
        word_t     data_b;
        word_t     immediate;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      halt;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t dest;
        word_t     alu_result;
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        logic      halt;
        logic      reg_write;
        reg_addr_t dest;
        word_t     result;
    } mem_wb_t;

endpackage

//--- mips_program_loader.sv
`timescale 1ns/100ps

module mips_program_loader (
    output logic                 o_load_ack,
    output logic                 o_imem_write,
    output mips_pkg::imem_addr_t o_imem_address,
    output mips_pkg::word_t      o_imem_word,

    input  logic                 i_load_req,
    input  mips_pkg::word_t      i_load_word,
    input  logic                 i_pc_reset,
    input  logic                 i_arst_n,
    input  logic                 i_clock
);

    mips_pkg::load_state_t state;
    mips_pkg::imem_addr_t  address;
    mips_pkg::word_t       word_q;

    // ------------------------------
    // Handshake FSM
    // ------------------------------
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state      <= mips_pkg::LOAD_IDLE;
            o_load_ack <= 1'b0;
        end else begin
            case (state)
                mips_pkg::LOAD_IDLE: begin
                    if (i_load_req) begin
                        state      <= mips_pkg::LOAD_WRITE;
                        o_load_ack <= 1'b1;
                    end
                end
                mips_pkg::LOAD_WRITE: begin
                    // Master may already have released the request
                    if (i_load_req) begin
                        state <= mips_pkg::LOAD_WAIT_RELEASE;
                    end else begin
                        state      <= mips_pkg::LOAD_IDLE;
                        o_load_ack <= 1'b0;
                    end
                end
                mips_pkg::LOAD_WAIT_RELEASE: begin
                    if (!i_load_req) begin
                        state      <= mips_pkg::LOAD_IDLE;
                        o_load_ack <= 1'b0;
                    end
                end
                default: begin
                    state      <= mips_pkg::LOAD_IDLE;
                    o_load_ack <= 1'b0;
                end
            endcase
        end
    end

    // Word captured when the request is first seen
    always_ff @(posedge i_clock) begin
        if (state == mips_pkg::LOAD_IDLE && i_load_req) begin
            word_q <= i_load_word;
        end
    end

    // Next instruction address, one step per written word
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            address <= '0;
        end else if (i_pc_reset) begin
            address <= '0;
        end else if (state == mips_pkg::LOAD_WRITE) begin
            address <= address + 1'b1;
        end
    end

    assign o_imem_write   = (state == mips_pkg::LOAD_WRITE);
    assign o_imem_address = address;
    assign o_imem_word    = word_q;

endmodule

//--- mips_fetch.sv
`timescale 1ns/100ps
`include "mips_params.svh"

module mips_fetch (
    output mips_pkg::if_id_t     o_if_id,

    input  logic                 i_imem_write,
    input  mips_pkg::imem_addr_t i_imem_address,
    input  mips_pkg::word_t      i_imem_word,
    input  logic                 i_run,
    input  logic                 i_pc_reset,
    input  logic                 i_arst_n,
    input  logic                 i_clock
);

    mips_pkg::word_t      imem [`MIPS_IMEM_DEPTH];
    mips_pkg::imem_addr_t pc;
    mips_pkg::word_t      instruction;
    logic                 halted;
    logic                 is_halt;

    // Instruction memory, written by the loader only
    always_ff @(posedge i_clock) begin
        if (i_imem_write) begin
            imem[i_imem_address] <= i_imem_word;
        end
    end

    assign instruction = imem[pc];
    assign is_halt     = (instruction[`MIPS_NB_DATA-1 -: `MIPS_NB_OP_FIELD] == `MIPS_HALT_OPCODE);

    // ------------------------------
    // PC and IF/ID register
    // ------------------------------
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= '0;
            halted  <= 1'b0;
            o_if_id <= '0;
        end else if (i_pc_reset) begin
            pc      <= '0;
            halted  <= 1'b0;
            o_if_id <= '0;
        end else if (i_run) begin
            if (halted) begin
                // Empty slots once the halt has gone down the pipe
                o_if_id <= '0;
            end else begin
                o_if_id.valid       <= 1'b1;
                o_if_id.halt        <= is_halt;
                o_if_id.instruction <= instruction;
                if (is_halt) begin
                    halted <= 1'b1;
                end else begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

endmodule

//--- mips_decode.sv
`timescale 1ns/100ps
`include "mips_params.svh"

module mips_decode (
    output mips_pkg::id_ex_t    o_id_ex,
    output mips_pkg::word_t     o_debug_read_reg,

    input  mips_pkg::if_id_t    i_if_id,
    input  mips_pkg::mem_wb_t   i_mem_wb,
    input  mips_pkg::reg_addr_t i_debug_read_reg_address,
    input  logic                i_run,
    input  logic                i_pc_reset,
    input  logic                i_arst_n,
    input  logic                i_clock
);

    localparam logic [`MIPS_NB_OP_FIELD-1:0] OP_RTYPE = 6'h00;
    localparam logic [`MIPS_NB_OP_FIELD-1:0] OP_ADDI  = 6'h08;
    localparam logic [`MIPS_NB_OP_FIELD-1:0] OP_LW    = 6'h23;
    localparam logic [`MIPS_NB_OP_FIELD-1:0] OP_SW    = 6'h2b;
    localparam logic [`MIPS_NB_OP_FIELD-1:0] FN_ADD   = 6'h20;
    localparam logic [`MIPS_NB_OP_FIELD-1:0] FN_SUB   = 6'h22;
    localparam logic [`MIPS_NB_OP_FIELD-1:0] FN_AND   = 6'h24;
    localparam logic [`MIPS_NB_OP_FIELD-1:0] FN_OR    = 6'h25;
    localparam logic [`MIPS_NB_OP_FIELD-1:0] FN_SLT   = 6'h2a;

    mips_pkg::word_t     regs [2**`MIPS_NB_REG_ADDRESS];
    mips_pkg::word_t     instr;
    logic [`MIPS_NB_OP_FIELD-1:0] opcode;
    logic [`MIPS_NB_OP_FIELD-1:0] funct;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    logic                wb_write;
    mips_pkg::id_ex_t    id_ex_next;

    assign instr  = i_if_id.instruction;
    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[`MIPS_NB_OP_FIELD-1:0];

    // ------------------------------
    // Register file
    // ------------------------------
    assign wb_write = i_mem_wb.valid && i_mem_wb.reg_write && (i_mem_wb.dest != '0);

    always_ff @(posedge i_clock) begin
        if (i_run && wb_write) begin
            regs[i_mem_wb.dest] <= i_mem_wb.result;
        end
    end

    // R0 reads zero and a write in this cycle is seen at once
    function automatic mips_pkg::word_t read_reg(input mips_pkg::reg_addr_t addr);
        if (addr == '0) begin
            read_reg = '0;
        end else if (wb_write && (i_mem_wb.dest == addr)) begin
            read_reg = i_mem_wb.result;
        end else begin
            read_reg = regs[addr];
        end
    endfunction

    always_comb begin
        o_debug_read_reg = read_reg(i_debug_read_reg_address);
    end

    // ------------------------------
    // Control decode
    // ------------------------------
    always_comb begin
        id_ex_next           = '0;
        id_ex_next.valid     = i_if_id.valid;
        id_ex_next.halt      = i_if_id.halt;
        id_ex_next.alu_op    = mips_pkg::ALU_ADD;
        id_ex_next.rs        = rs;
        id_ex_next.rt        = rt;
        id_ex_next.data_a    = read_reg(rs);
        id_ex_next.data_b    = read_reg(rt);
        id_ex_next.immediate = {{(`MIPS_NB_DATA-16){instr[15]}}, instr[15:0]};
        if (i_if_id.valid) begin
            case (opcode)
                OP_RTYPE: begin
                    id_ex_next.dest      = rd;
                    id_ex_next.reg_write = 1'b1;
                    case (funct)
                        FN_ADD:  id_ex_next.alu_op = mips_pkg::ALU_ADD;
                        FN_SUB:  id_ex_next.alu_op = mips_pkg::ALU_SUB;
                        FN_AND:  id_ex_next.alu_op = mips_pkg::ALU_AND;
                        FN_OR:   id_ex_next.alu_op = mips_pkg::ALU_OR;
                        FN_SLT:  id_ex_next.alu_op = mips_pkg::ALU_SLT;
                        default: id_ex_next.reg_write = 1'b0;
                    endcase
                end
                OP_ADDI: begin
                    id_ex_next.dest        = rt;
                    id_ex_next.alu_src_imm = 1'b1;
                    id_ex_next.reg_write   = 1'b1;
                end
                OP_LW: begin
                    id_ex_next.dest        = rt;
                    id_ex_next.alu_src_imm = 1'b1;
                    id_ex_next.mem_read    = 1'b1;
                    id_ex_next.reg_write   = 1'b1;
                end
                OP_SW: begin
                    id_ex_next.alu_src_imm = 1'b1;
                    id_ex_next.mem_write   = 1'b1;
                end
                // Halt and unknown opcodes write nothing
                default: ;
            endcase
        end
    end

    // ID/EX register
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_id_ex <= '0;
        end else if (i_pc_reset) begin
            o_id_ex <= '0;
        end else if (i_run) begin
            o_id_ex <= id_ex_next;
        end
    end

endmodule

//--- mips_execute.sv
`timescale 1ns/100ps

module mips_execute (
    output mips_pkg::ex_mem_t o_ex_mem,

    input  mips_pkg::id_ex_t  i_id_ex,
    input  mips_pkg::mem_wb_t i_mem_wb,
    input  logic              i_run,
    input  logic              i_pc_reset,
    input  logic              i_arst_n,
    input  logic              i_clock
);

    mips_pkg::word_t operand_a;
    mips_pkg::word_t operand_b;
    mips_pkg::word_t alu_b;
    mips_pkg::word_t alu_result;

    // ------------------------------
    // Forwarding
    // ------------------------------
    // Newest writer wins with EX/MEM before MEM/WB
    function automatic mips_pkg::word_t forward(input mips_pkg::reg_addr_t addr,
                                                input mips_pkg::word_t     decoded);
        if (addr != '0 && o_ex_mem.valid && o_ex_mem.reg_write && o_ex_mem.dest == addr) begin
            forward = o_ex_mem.alu_result;
        end else if (addr != '0 && i_mem_wb.valid && i_mem_wb.reg_write
                     && i_mem_wb.dest == addr) begin
            forward = i_mem_wb.result;
        end else begin
            forward = decoded;
        end
    endfunction

    always_comb begin
        operand_a = forward(i_id_ex.rs, i_id_ex.data_a);
        operand_b = forward(i_id_ex.rt, i_id_ex.data_b);
    end

    assign alu_b = i_id_ex.alu_src_imm ? i_id_ex.immediate : operand_b;

    // ALU
    always_comb begin
        case (i_id_ex.alu_op)
            mips_pkg::ALU_SUB: alu_result = operand_a - alu_b;
            mips_pkg::ALU_AND: alu_result = operand_a & alu_b;
            mips_pkg::ALU_OR:  alu_result = operand_a | alu_b;
            mips_pkg::ALU_SLT: alu_result = mips_pkg::word_t'($signed(operand_a) < $signed(alu_b));
            default:           alu_result = operand_a + alu_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ex_mem <= '0;
        end else if (i_pc_reset) begin
            o_ex_mem <= '0;
        end else if (i_run) begin
            o_ex_mem.valid      <= i_id_ex.valid;
            o_ex_mem.halt       <= i_id_ex.halt;
            o_ex_mem.mem_read   <= i_id_ex.mem_read;
            o_ex_mem.mem_write  <= i_id_ex.mem_write;
            o_ex_mem.reg_write  <= i_id_ex.reg_write;
            o_ex_mem.dest       <= i_id_ex.dest;
            o_ex_mem.alu_result <= alu_result;
            o_ex_mem.store_data <= operand_b;
        end
    end

endmodule

//--- mips_memory.sv
`timescale 1ns/100ps
`include "mips_params.svh"

module mips_memory (
    output mips_pkg::mem_wb_t   o_mem_wb,
    output mips_pkg::word_t     o_debug_read_mem,
    output logic                o_is_program_end,

    input  mips_pkg::ex_mem_t   i_ex_mem,
    input  mips_pkg::mem_addr_t i_debug_read_mem_address,
    input  logic                i_run,
    input  logic                i_pc_reset,
    input  logic                i_arst_n,
    input  logic                i_clock
);

    mips_pkg::word_t     dmem [`MIPS_DMEM_DEPTH];
    mips_pkg::mem_addr_t address;
    mips_pkg::word_t     wb_result;

    // Byte address to word index
    assign address = i_ex_mem.alu_result[`MIPS_NB_MEM_ADDRESS+1:2];

    always_ff @(posedge i_clock) begin
        if (i_run && i_ex_mem.valid && i_ex_mem.mem_write) begin
            dmem[address] <= i_ex_mem.store_data;
        end
    end

    assign wb_result        = i_ex_mem.mem_read ? dmem[address] : i_ex_mem.alu_result;
    assign o_debug_read_mem = dmem[i_debug_read_mem_address];

    // ------------------------------
    // MEM/WB register and end flag
    // ------------------------------
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mem_wb         <= '0;
            o_is_program_end <= 1'b0;
        end else if (i_pc_reset) begin
            o_mem_wb         <= '0;
            o_is_program_end <= 1'b0;
        end else if (i_run) begin
            o_mem_wb.valid     <= i_ex_mem.valid;
            o_mem_wb.halt      <= i_ex_mem.halt;
            o_mem_wb.reg_write <= i_ex_mem.reg_write;
            o_mem_wb.dest      <= i_ex_mem.dest;
            o_mem_wb.result    <= wb_result;
            // Halt leaves MEM/WB, so every older write is done
            if (o_mem_wb.valid && o_mem_wb.halt) begin
                o_is_program_end <= 1'b1;
            end
        end
    end

endmodule

//--- mips.sv
`timescale 1ns/100ps

module mips (
    output mips_pkg::word_t     o_debug_read_reg,
    output mips_pkg::word_t     o_debug_read_mem,
    output logic                o_is_program_end,
    output logic                o_load_ack,

    input  mips_pkg::reg_addr_t i_debug_read_reg_address,
    input  mips_pkg::mem_addr_t i_debug_read_mem_address,
    input  logic                i_load_req,
    input  mips_pkg::word_t     i_load_word,
    input  logic                i_run,
    input  logic                i_pc_reset,
    input  logic                i_arst_n,
    input  logic                i_clock
);

    logic                 imem_write;
    mips_pkg::imem_addr_t imem_address;
    mips_pkg::word_t      imem_word;
    mips_pkg::if_id_t     if_id;
    mips_pkg::id_ex_t     id_ex;
    mips_pkg::ex_mem_t    ex_mem;
    mips_pkg::mem_wb_t    mem_wb;

    // ------------------------------
    // Program loading
    // ------------------------------
    mips_program_loader u_program_loader (
        .o_load_ack     (o_load_ack),
        .o_imem_write   (imem_write),
        .o_imem_address (imem_address),
        .o_imem_word    (imem_word),
        .i_load_req     (i_load_req),
        .i_load_word    (i_load_word),
        .i_pc_reset     (i_pc_reset),
        .i_arst_n       (i_arst_n),
        .i_clock        (i_clock)
    );

    // ------------------------------
    // Pipeline stages
    // ------------------------------
    mips_fetch u_fetch (
        .o_if_id        (if_id),
        .i_imem_write   (imem_write),
        .i_imem_address (imem_address),
        .i_imem_word    (imem_word),
        .i_run          (i_run),
        .i_pc_reset     (i_pc_reset),
        .i_arst_n       (i_arst_n),
        .i_clock        (i_clock)
    );

    mips_decode u_decode (
        .o_id_ex                  (id_ex),
        .o_debug_read_reg         (o_debug_read_reg),
        .i_if_id                  (if_id),
        .i_mem_wb                 (mem_wb),
        .i_debug_read_reg_address (i_debug_read_reg_address),
        .i_run                    (i_run),
        .i_pc_reset               (i_pc_reset),
        .i_arst_n                 (i_arst_n),
        .i_clock                  (i_clock)
    );

    mips_execute u_execute (
        .o_ex_mem   (ex_mem),
        .i_id_ex    (id_ex),
        .i_mem_wb   (mem_wb),
        .i_run      (i_run),
        .i_pc_reset (i_pc_reset),
        .i_arst_n   (i_arst_n),
        .i_clock    (i_clock)
    );

    mips_memory u_memory (
        .o_mem_wb                 (mem_wb),
        .o_debug_read_mem         (o_debug_read_mem),
        .o_is_program_end         (o_is_program_end),
        .i_ex_mem                 (ex_mem),
        .i_debug_read_mem_address (i_debug_read_mem_address),
        .i_run                    (i_run),
        .i_pc_reset               (i_pc_reset),
        .i_arst_n                 (i_arst_n),
        .i_clock                  (i_clock)
    );

endmodule

//--- tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic o_clock,
    output logic o_arst_n
);

    initial begin
        o_clock = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clock = ~o_clock;
    end

    // Reset low for the first cycles, released on a rising edge
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clock);
        o_arst_n <= 1'b1;
    end

endmodule

//--- mips_properties.sv
`timescale 1ns/100ps

module mips_properties (
    input logic            i_clock,
    input logic            i_arst_n,
    input logic            i_pc_reset,
    input logic            i_load_req,
    input mips_pkg::word_t i_load_word,
    input logic            o_load_ack,
    input logic            o_is_program_end
);

    int unsigned error_count = 0;

    // ------------------------------
    // Load handshake
    // ------------------------------
    ack_rise: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $rose(o_load_ack) |-> i_load_req)
        else begin
            $error("load ack rose without a pending request");
            error_count++;
        end

    // Ack may only drop once the request was seen low
    ack_fall: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $fell(o_load_ack) |-> !$past(i_load_req))
        else begin
            $error("load ack dropped while the request was still high");
            error_count++;
        end

    word_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_load_req && $past(i_load_req) |-> $stable(i_load_word))
        else begin
            $error("load word changed during a request");
            error_count++;
        end

    // ------------------------------
    // Program end and reset state
    // ------------------------------
    end_sticky: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        o_is_program_end && !i_pc_reset |=> o_is_program_end)
        else begin
            $error("program end flag dropped without a pc reset");
            error_count++;
        end

    reset_state: assert property (@(posedge i_clock)
        $rose(i_arst_n) |-> !o_load_ack && !o_is_program_end)
        else begin
            $error("load ack or program end high after reset");
            error_count++;
        end

endmodule

bind mips mips_properties u_properties (
    .i_clock          (i_clock),
    .i_arst_n         (i_arst_n),
    .i_pc_reset       (i_pc_reset),
    .i_load_req       (i_load_req),
    .i_load_word      (i_load_word),
    .o_load_ack       (o_load_ack),
    .o_is_program_end (o_is_program_end)
);

//--- mips_tb.sv
`timescale 1ns/100ps
`include "mips_params.svh"

module mips_tb;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] FN_ADD   = 6'h20;
    localparam logic [5:0] FN_SUB   = 6'h22;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam int         NUM_REGS = 2 ** `MIPS_NB_REG_ADDRESS;
    localparam mips_pkg::word_t HALT = {`MIPS_HALT_OPCODE, 26'd0};
    // Six loads of up to 32 words at 4 cycles, a 160 cycle sweep and a short run each
    localparam int CYCLE_LIMIT = 4000;

    logic                clock;
    logic                arst_n;
    logic                pc_reset;
    logic                run;
    logic                load_req;
    logic                load_ack;
    logic                is_program_end;
    mips_pkg::word_t     load_word;
    mips_pkg::reg_addr_t debug_reg_address;
    mips_pkg::mem_addr_t debug_mem_address;
    mips_pkg::word_t     debug_read_reg;
    mips_pkg::word_t     debug_read_mem;

    // Reference machine state kept across tests like the DUT memories
    mips_pkg::word_t     prog[$];
    mips_pkg::word_t     ref_regs[NUM_REGS];
    mips_pkg::word_t     ref_mem[`MIPS_DMEM_DEPTH];
    bit                  reg_known[NUM_REGS];
    bit                  mem_known[`MIPS_DMEM_DEPTH];
    int                  seed         = 32'h82f;
    int                  cycles       = 0;
    int                  mismatches   = 0;
    int                  tests_run    = 0;
    int                  tests_failed = 0;

    tb_clock clock_gen (
        .o_clock  (clock),
        .o_arst_n (arst_n)
    );

    mips mips_inst (
        .o_debug_read_reg         (debug_read_reg),
        .o_debug_read_mem         (debug_read_mem),
        .o_is_program_end         (is_program_end),
        .o_load_ack               (load_ack),
        .i_debug_read_reg_address (debug_reg_address),
        .i_debug_read_mem_address (debug_mem_address),
        .i_load_req               (load_req),
        .i_load_word              (load_word),
        .i_run                    (run),
        .i_pc_reset               (pc_reset),
        .i_arst_n                 (arst_n),
        .i_clock                  (clock)
    );

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run did not finish: timeout");
            $display("Some tests failed");
            $finish;
        end
    end

    // ------------------------------
    // Instruction encoding
    // ------------------------------
    function automatic mips_pkg::word_t rtype(input logic [5:0] funct, input int rd,
                                              input int rs, input int rt);
        rtype = {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic mips_pkg::word_t itype(input logic [5:0] op, input int rt,
                                              input int rs, input int imm);
        itype = {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // Sequential model of the kept instructions
    task automatic interpret();
        mips_pkg::word_t instr;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t result;
        int              dest;
        int              pc;
        bit              halted;
        halted = 1'b0;
        for (pc = 0; pc < prog.size() && !halted; pc++) begin
            instr  = prog[pc];
            a      = ref_regs[instr[25:21]];
            b      = ref_regs[instr[20:16]];
            result = a + {{16{instr[15]}}, instr[15:0]};
            dest   = 0;
            case (instr[31:26])
                OP_RTYPE: begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        FN_ADD:  result = a + b;
                        FN_SUB:  result = a - b;
                        FN_AND:  result = a & b;
                        FN_OR:   result = a | b;
                        FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: dest = 0;
                    endcase
                end
                OP_ADDI: dest = instr[20:16];
                OP_LW: begin
                    dest   = instr[20:16];
                    result = ref_mem[result[8:2]];
                end
                OP_SW: begin
                    ref_mem[result[8:2]]   = b;
                    mem_known[result[8:2]] = 1'b1;
                end
                `MIPS_HALT_OPCODE: halted = 1'b1;
                default: ;
            endcase
            if (dest != 0) begin
                ref_regs[dest]  = result;
                reg_known[dest] = 1'b1;
            end
        end
    endtask

    // ------------------------------
    // DUT access
    // ------------------------------
    task automatic load_program();
        foreach (prog[i]) begin
            load_word <= prog[i];
            load_req  <= 1'b1;
            do @(posedge clock); while (!load_ack);
            load_req  <= 1'b0;
            do @(posedge clock); while (load_ack);
        end
    endtask

    task automatic check_state();
        int r;
        int m;
        for (r = 0; r < NUM_REGS; r++) begin
            debug_reg_address <= mips_pkg::reg_addr_t'(r);
            @(posedge clock);
            if (reg_known[r]) begin
                assert (debug_read_reg === ref_regs[r]) else begin
                    $display("MISMATCH at %0t: o_debug_read_reg[%0d] expected %h actual %h",
                             $time, r, ref_regs[r], debug_read_reg);
                    mismatches++;
                end
            end
        end
        for (m = 0; m < `MIPS_DMEM_DEPTH; m++) begin
            debug_mem_address <= mips_pkg::mem_addr_t'(m);
            @(posedge clock);
            if (mem_known[m]) begin
                assert (debug_read_mem === ref_mem[m]) else begin
                    $display("MISMATCH at %0t: o_debug_read_mem[%0d] expected %h actual %h",
                             $time, m, ref_mem[m], debug_read_mem);
                    mismatches++;
                end
            end
        end
    endtask

    // Restart, load, run to the end flag, then sweep both debug ports
    task automatic run_test(input string name);
        int          errors_before;
        int unsigned asserts_before;
        errors_before  = mismatches;
        asserts_before = mips_inst.u_properties.error_count;
        interpret();
        pc_reset <= 1'b1;
        @(posedge clock);
        pc_reset <= 1'b0;
        @(posedge clock);
        load_program();
        run <= 1'b1;
        do @(posedge clock); while (!is_program_end);
        run <= 1'b0;
        check_state();
        tests_run++;
        if (mismatches == errors_before
            && mips_inst.u_properties.error_count == asserts_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: errors found", name);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [5:0]  functs[5];
        logic [31:0] pick;
        int          i;
        functs            = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};
        pc_reset          <= 1'b0;
        run               <= 1'b0;
        load_req          <= 1'b0;
        load_word         <= '0;
        debug_reg_address <= '0;
        debug_mem_address <= '0;
        for (i = 0; i < NUM_REGS; i++) begin
            ref_regs[i]  = '0;
            reg_known[i] = (i == 0);
        end
        while (arst_n !== 1'b1) @(posedge clock);

        prog = '{itype(OP_ADDI, 1, 0, 5), itype(OP_ADDI, 2, 0, -3),
                 itype(OP_ADDI, 3, 0, 100), HALT};
        run_test("program_load");

        prog = '{itype(OP_ADDI, 4, 0, 12), itype(OP_ADDI, 5, 0, -7),
                 itype(OP_ADDI, 6, 0, 16'h0f0f), rtype(FN_ADD, 7, 4, 5),
                 rtype(FN_SUB, 8, 4, 5), rtype(FN_AND, 9, 4, 6), rtype(FN_OR, 10, 5, 6),
                 rtype(FN_SLT, 11, 5, 4), rtype(FN_SLT, 12, 4, 5), HALT};
        run_test("rtype");

        // Dependencies at distance one, two and three
        prog = '{itype(OP_ADDI, 13, 0, 1), itype(OP_ADDI, 13, 13, 2),
                 itype(OP_ADDI, 13, 13, 3), rtype(FN_ADD, 14, 13, 13),
                 rtype(FN_ADD, 15, 14, 13), rtype(FN_ADD, 16, 15, 14),
                 rtype(FN_SUB, 17, 16, 13), HALT};
        run_test("forwarding");

        prog = '{itype(OP_ADDI, 18, 0, 16'h55), itype(OP_ADDI, 19, 0, -2),
                 itype(OP_SW, 18, 0, 0), itype(OP_SW, 19, 0, 4), itype(OP_ADDI, 20, 0, 8),
                 itype(OP_SW, 18, 20, 4), itype(OP_LW, 21, 0, 0), itype(OP_LW, 22, 0, 4),
                 itype(OP_LW, 25, 0, 12), rtype(FN_ADD, 24, 21, 22),
                 itype(OP_SW, 24, 20, 16), rtype(FN_ADD, 26, 25, 18), HALT};
        run_test("memory");

        // Reads of r0 one and two slots after writes to it
        prog = '{itype(OP_ADDI, 27, 0, 11), itype(OP_ADDI, 28, 0, 22),
                 itype(OP_ADDI, 0, 0, 77), rtype(FN_ADD, 0, 1, 1),
                 itype(OP_ADDI, 29, 0, 0), rtype(FN_ADD, 30, 0, 1),
                 itype(6'h3e, 27, 1, 16'h1234), rtype(6'h27, 28, 1, 1), HALT};
        run_test("reg0_unknown");

        // Random ALU program on registers 1 to 8
        prog.delete();
        for (i = 1; i <= 8; i++) begin
            prog.push_back(itype(OP_ADDI, i, 0, $random(seed)));
        end
        for (i = 0; i < 20; i++) begin
            pick = $random(seed);
            prog.push_back(rtype(functs[pick[2:0] % 5], 1 + pick[5:3], 1 + pick[8:6],
                                 1 + pick[11:9]));
        end
        prog.push_back(HALT);
        run_test("restart_random");

        $display("Tests run: %0d, failed: %0d, mismatches: %0d, assertion errors: %0d",
                 tests_run, tests_failed, mismatches, mips_inst.u_properties.error_count);
        if (tests_failed == 0 && mips_inst.u_properties.error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- mips.f
+incdir+.
mips_pkg.sv
mips_program_loader.sv
mips_fetch.sv
mips_decode.sv
mips_execute.sv
mips_memory.sv
mips.sv
tb_clock.sv
mips_properties.sv
mips_tb.sv
